//--- compile.f
design/recovery_pkg.sv
design/recovery_cmd_if.sv
design/recovery_csr_if.sv
design/recovery_receiver.sv
design/recovery_rx_queue.sv
design/recovery_executor.sv
design/recovery_csr.sv
design/recovery_top.sv
verification/recovery_sva.sv
verification/recovery_checker.sv
verification/tb_recovery.sv

//--- run.sh
#!/bin/sh
# Builds the recovery testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_recovery -o sim_recovery; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_recovery 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if printf '%s\n' "$out" | grep -q '^=== PASS ===$'; then
  exit 0
fi
exit 1

//--- verification/tb_recovery.sv
// Testbench top for the recovery command block, drives packets and collects read responses
module tb_recovery
  import recovery_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 400;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        byte_valid_i;
  logic [7:0]  byte_i;
  logic        byte_last_i;
  logic        pkt_rd_i;
  logic        res_ready_i;
  logic        res_dready_i;
  logic [31:0] hw_status_i;
  logic        payload_ack_i;
  logic        busy_o;
  logic        res_valid_o;
  logic [15:0] res_len_o;
  logic        res_dvalid_o;
  logic [7:0]  res_data_o;
  logic        res_dlast_o;
  logic        payload_available_o;
  logic        image_activated_o;
  int          err_cnt;
  int          chk_cnt;
  logic        hung = 1'b0;
  logic [7:0]  pkt_data [32];
  logic [7:0]  rd_cmds [7] = '{8'd34, 8'd36, 8'd37, 8'd38, 8'd39, 8'd40, 8'd50};

  always #20 clk_i = ~clk_i;

  recovery_top u_dut (.*);

  recovery_checker u_checker (.*, .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt));

  bind recovery_top recovery_sva u_sva (.*);

  task automatic raise_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    hung = 1'b1;
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last, input logic rd);
    @(negedge clk_i);
    byte_valid_i = 1'b1;
    byte_i       = b;
    byte_last_i  = last;
    pkt_rd_i     = rd;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (busy_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (busy_o) raise_timeout("busy_o to fall");
  endtask

  task automatic end_packet();
    int t;
    @(negedge clk_i);
    byte_valid_i = 1'b0;
    byte_last_i  = 1'b0;
    pkt_rd_i     = 1'b0;
    t = 0;
    while (!busy_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (!busy_o) raise_timeout("busy_o to rise");
  endtask

  // Command, little-endian length, data, then XOR checksum
  task automatic write_pkt(input logic [7:0] c, input int n, input bit corrupt);
    logic [15:0] len16;
    logic [7:0]  pec;
    len16 = 16'(n);
    pec   = c ^ len16[7:0] ^ len16[15:8];
    send_byte(c, 1'b0, 1'b0);
    send_byte(len16[7:0], 1'b0, 1'b0);
    send_byte(len16[15:8], 1'b0, 1'b0);
    for (int i = 0; i < n; i++) begin
      send_byte(pkt_data[i], 1'b0, 1'b0);
      pec = pec ^ pkt_data[i];
    end
    send_byte(corrupt ? (pec ^ 8'h5A) : pec, 1'b1, 1'b0);
    end_packet();
    wait_idle();
  endtask

  task automatic read_reg(input logic [7:0] c, input bit stall);
    int t;
    bit done;
    send_byte(c, 1'b1, 1'b1);
    end_packet();
    t    = 0;
    done = 1'b0;
    while (!done && t < WAIT_LIMIT) begin
      res_ready_i  = stall ? 1'($urandom) : 1'b1;
      res_dready_i = stall ? 1'($urandom) : 1'b1;
      if (res_dvalid_o && res_dready_i && res_dlast_o) done = 1'b1;
      @(negedge clk_i);
      t++;
    end
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
    if (!done) raise_timeout("the last response byte");
    wait_idle();
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) pkt_data[i] = 8'($urandom);
  endtask

  initial begin
    wait (hung);
    $display("Run stopped early after a handshake timeout");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h7b1c_c3c9));
    rst_ni        = 1'b0;
    byte_valid_i  = 1'b0;
    byte_i        = 8'h00;
    byte_last_i   = 1'b0;
    pkt_rd_i      = 1'b0;
    res_ready_i   = 1'b0;
    res_dready_i  = 1'b0;
    payload_ack_i = 1'b0;
    hw_status_i   = $urandom;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    read_reg(CMD_PROT_CAP, 1'b0);
    read_reg(CMD_RECOVERY_STATUS, 1'b0);
    // Random control bytes, then the activation code in byte 2
    fill_random(3);
    write_pkt(CMD_RECOVERY_CTRL, 3, 1'b0);
    read_reg(CMD_RECOVERY_CTRL, 1'b0);
    pkt_data[0] = 8'h01;
    pkt_data[1] = 8'h02;
    pkt_data[2] = IMAGE_ACTIVATE_CODE;
    write_pkt(CMD_RECOVERY_CTRL, 3, 1'b0);
    read_reg(CMD_RECOVERY_CTRL, 1'b0);
    fill_random(3);
    write_pkt(CMD_RECOVERY_CTRL, 3, 1'b1);
    // CRC status is visible only until the next command completes
    read_reg(CMD_DEVICE_STATUS, 1'b0);
    read_reg(CMD_RECOVERY_CTRL, 1'b0);
    read_reg(CMD_DEVICE_STATUS, 1'b0);
    fill_random(4);
    write_pkt(CMD_HW_STATUS, 4, 1'b0);
    hw_status_i = $urandom;
    read_reg(CMD_HW_STATUS, 1'b0);
    fill_random(16);
    write_pkt(CMD_INDIRECT_FIFO_DATA, 1 + int'($urandom % 16), 1'b0);
    repeat (3) @(negedge clk_i);
    payload_ack_i = 1'b1;
    @(negedge clk_i);
    payload_ack_i = 1'b0;
    fill_random(20);
    write_pkt(CMD_INDIRECT_FIFO_DATA, 20, 1'b0);
    read_reg(CMD_DEVICE_STATUS, 1'b0);
    repeat (12) read_reg(rd_cmds[$urandom % 7], 1'b1);
    repeat (3) @(negedge clk_i);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verification/recovery_checker.sv
// Watches the recovery top-level ports, models the registers and compares every response
module recovery_checker
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        byte_valid_i,
  input  logic [7:0]  byte_i,
  input  logic        byte_last_i,
  input  logic        pkt_rd_i,
  input  logic        busy_o,
  input  logic        res_valid_o,
  input  logic        res_ready_i,
  input  logic [15:0] res_len_o,
  input  logic        res_dvalid_o,
  input  logic        res_dready_i,
  input  logic [7:0]  res_data_o,
  input  logic        res_dlast_o,
  input  logic [31:0] hw_status_i,
  input  logic        payload_ack_i,
  input  logic        payload_available_o,
  input  logic        image_activated_o,
  output int          err_cnt_o,
  output int          chk_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int          errs = 0;
  int          checks = 0;
  logic [31:0] ctrl_m;
  logic [31:0] reset_m;
  logic [7:0]  proto_m;
  logic        flag_m;
  logic        pend;
  int          bcnt;
  logic [7:0]  cmd_b;
  logic [7:0]  pec;
  logic [15:0] len_b;
  logic [31:0] word_b;
  logic [31:0] exp_word;
  logic [15:0] exp_len;
  int          idx;
  logic [7:0]  c;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  function automatic logic [15:0] ref_len(input logic [7:0] code);
    case (code)
      8'd34, 8'd36, 8'd40: return 16'd4;
      8'd37, 8'd38:        return 16'd3;
      8'd39:               return 16'd2;
      default:             return 16'd4;
    endcase
  endfunction

  // Expected read word, bytes leave least significant first
  function automatic logic [31:0] ref_word(input logic [7:0] code);
    case (code)
      8'd34:   return PROT_CAP_VALUE;
      8'd36:   return {16'h0000, proto_m, 8'h00};
      8'd37:   return reset_m;
      8'd38:   return ctrl_m;
      8'd39:   return RECOVERY_STATUS_VALUE;
      8'd40:   return hw_status_i;
      default: return 32'h0000_0000;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("[ERROR] %0d ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_m  = '0;
      reset_m = '0;
      proto_m = 8'h00;
      flag_m  = 1'b0;
      pend    = 1'b0;
      bcnt    = 0;
      idx     = 0;
      exp_len = '0;
    end else begin
      // Idle outputs only settle once the command is finished
      if (!busy_o && !pend) begin
        compare("res_valid_o", 32'(res_valid_o), 32'd0);
        compare("res_dvalid_o", 32'(res_dvalid_o), 32'd0);
        compare("payload_available_o", 32'(payload_available_o), 32'(flag_m));
        compare("image_activated_o", 32'(image_activated_o),
                32'(ctrl_m[23:16] == IMAGE_ACTIVATE_CODE));
      end
      // Command is raised one cycle after the last packet byte
      if (pend) begin
        compare("busy_o", 32'(busy_o), 32'd1);
        pend = 1'b0;
      end
      if (res_valid_o && res_ready_i) compare("res_len_o", 32'(res_len_o), 32'(exp_len));
      if (res_dvalid_o && res_dready_i) begin
        compare("res_data_o", 32'(res_data_o), 32'(exp_word[8*(idx%4) +: 8]));
        compare("res_dlast_o", 32'(res_dlast_o), 32'(idx == int'(exp_len) - 1));
        idx++;
      end
      if (payload_ack_i) flag_m = 1'b0;
      if (byte_valid_i && !busy_o) begin
        if (byte_last_i) begin
          c    = (bcnt == 0) ? byte_i : cmd_b;
          pend = 1'b1;
          if (pkt_rd_i) begin
            exp_len  = ref_len(c);
            exp_word = ref_word(c);
            idx      = 0;
            proto_m  = 8'h00;
          end else if (byte_i != pec) begin
            proto_m = 8'h04;
          end else if (len_b > 16'd16) begin
            proto_m = 8'h03;
          end else begin
            proto_m = 8'h00;
            if (len_b != 16'd0 && c == 8'd37) reset_m = word_b;
            if (len_b != 16'd0 && c == 8'd38) ctrl_m = word_b;
            if (c == 8'd47) flag_m = 1'b1;
          end
          bcnt = 0;
        end else begin
          if (bcnt == 0) begin
            cmd_b  = byte_i;
            pec    = byte_i;
            len_b  = '0;
            word_b = '0;
          end else begin
            pec = pec ^ byte_i;
          end
          if (bcnt == 1) len_b[7:0] = byte_i;
          if (bcnt == 2) len_b[15:8] = byte_i;
          if (bcnt >= 3 && bcnt < 7) word_b[8*(bcnt-3) +: 8] = byte_i;
          bcnt++;
        end
      end
    end
  end

endmodule

//--- verification/recovery_sva.sv
// Response stream and handshake assertions, bound into the recovery top level by the testbench
module recovery_sva (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       res_valid_o,
  input logic       res_ready_i,
  input logic       res_dvalid_o,
  input logic       res_dready_i,
  input logic       res_dlast_o,
  input logic [7:0] res_data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // A stalled byte stays on the bus unchanged
  dvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o && !res_dready_i |=> res_dvalid_o && $stable(res_data_o))
    else $error("res_dvalid_o or res_data_o changed while res_dready_i was low");

  // Nothing follows the last byte of a response
  dlast_ends_stream: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o && res_dready_i && res_dlast_o |=> !res_dvalid_o && !res_dlast_o)
    else $error("res_dvalid_o or res_dlast_o still high after the last byte");

  valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o)
    else $error("res_valid_o dropped before res_ready_i");

endmodule

//--- design/recovery_top.sv
// Top level of the recovery command block, joining receiver, queue, executor and registers
module recovery_top (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        byte_valid_i,
  input  logic [7:0]  byte_i,
  input  logic        byte_last_i,
  input  logic        pkt_rd_i,
  input  logic        res_ready_i,
  input  logic        res_dready_i,
  input  logic [31:0] hw_status_i,
  input  logic        payload_ack_i,
  output logic        busy_o,
  output logic        res_valid_o,
  output logic [15:0] res_len_o,
  output logic        res_dvalid_o,
  output logic [7:0]  res_data_o,
  output logic        res_dlast_o,
  output logic        payload_available_o,
  output logic        image_activated_o
);

  logic        push;
  logic [31:0] push_word;
  logic        rx_req;
  logic        rx_clr;
  logic        rx_ack;
  logic [31:0] rx_word;

  recovery_cmd_if cmd_if ();
  recovery_csr_if csr_if ();

  recovery_receiver u_receiver (
    .clk_i, .rst_ni, .byte_valid_i, .byte_i, .byte_last_i, .pkt_rd_i,
    .cmd         (cmd_if.source),
    .push_o      (push),
    .push_word_o (push_word),
    .busy_o
  );

  recovery_rx_queue u_rx_queue (
    .clk_i, .rst_ni,
    .push_i      (push),
    .push_word_i (push_word),
    .rx_req_i    (rx_req),
    .rx_clr_i    (rx_clr),
    .rx_ack_o    (rx_ack),
    .rx_word_o   (rx_word)
  );

  recovery_executor u_executor (
    .clk_i, .rst_ni,
    .cmd       (cmd_if.sink),
    .rx_req_o  (rx_req),
    .rx_clr_o  (rx_clr),
    .rx_ack_i  (rx_ack),
    .rx_word_i (rx_word),
    .csr       (csr_if.master),
    .res_ready_i, .res_dready_i, .res_valid_o, .res_len_o,
    .res_dvalid_o, .res_data_o, .res_dlast_o
  );

  recovery_csr u_csr (
    .clk_i, .rst_ni,
    .csr (csr_if.slave),
    .hw_status_i, .payload_ack_i, .payload_available_o, .image_activated_o
  );

endmodule

//--- design/recovery_csr.sv
// Recovery register bank with device status, image activation and payload-available flag
module recovery_csr
  import recovery_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  recovery_csr_if.slave csr,
  input  logic [31:0]   hw_status_i,
  input  logic          payload_ack_i,
  output logic          payload_available_o,
  output logic          image_activated_o
);

  logic [31:0]      device_reset_q;
  logic [31:0]      recovery_ctrl_q;
  protocol_status_e protocol_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q      <= '0;
      recovery_ctrl_q     <= '0;
      protocol_q          <= PROTOCOL_OK;
      payload_available_o <= 1'b0;
    end else begin
      if (csr.we) begin
        unique case (csr.sel)
          REG_DEVICE_RESET:  device_reset_q <= csr.wdata;
          REG_RECOVERY_CTRL: recovery_ctrl_q <= csr.wdata;
          default: ;
        endcase
      end
      if (csr.status_we) begin
        protocol_q <= csr.status_code;
      end
      // Set has priority over the firmware acknowledge
      if (csr.payload_set) payload_available_o <= 1'b1;
      else if (payload_ack_i) payload_available_o <= 1'b0;
    end
  end

  always_comb begin
    unique case (csr.sel)
      REG_PROT_CAP:        csr.rdata = PROT_CAP_VALUE;
      REG_DEVICE_STATUS:   csr.rdata = {16'h0000, protocol_q, 8'h00};
      REG_DEVICE_RESET:    csr.rdata = device_reset_q;
      REG_RECOVERY_CTRL:   csr.rdata = recovery_ctrl_q;
      REG_RECOVERY_STATUS: csr.rdata = RECOVERY_STATUS_VALUE;
      REG_HW_STATUS:       csr.rdata = hw_status_i;
      default:             csr.rdata = '0;
    endcase
  end

  assign image_activated_o = (recovery_ctrl_q[23:16] == IMAGE_ACTIVATE_CODE);

endmodule

//--- design/recovery_executor.sv
// Runs decoded recovery commands against the register bank and streams read responses
module recovery_executor
  import recovery_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  recovery_cmd_if.sink   cmd,
  output logic           rx_req_o,
  output logic           rx_clr_o,
  input  logic           rx_ack_i,
  input  logic [31:0]    rx_word_i,
  recovery_csr_if.master csr,
  input  logic           res_ready_i,
  input  logic           res_dready_i,
  output logic           res_valid_o,
  output logic [15:0]    res_len_o,
  output logic           res_dvalid_o,
  output logic [7:0]     res_data_o,
  output logic           res_dlast_o
);

  exec_state_e state_q;
  exec_state_e state_d;
  logic [15:0] dcnt;
  logic [1:0]  bcnt;
  logic        first_q;
  logic [31:0] csr_data;
  logic [15:0] rd_len;
  logic        writable;
  logic        byte_xfer;

  assign byte_xfer = res_dvalid_o && res_dready_i;

  // Target register follows the held command
  always_comb begin
    unique case (cmd.cmd)
      CMD_PROT_CAP:           csr.sel = REG_PROT_CAP;
      CMD_DEVICE_STATUS:      csr.sel = REG_DEVICE_STATUS;
      CMD_DEVICE_RESET:       csr.sel = REG_DEVICE_RESET;
      CMD_RECOVERY_CTRL:      csr.sel = REG_RECOVERY_CTRL;
      CMD_RECOVERY_STATUS:    csr.sel = REG_RECOVERY_STATUS;
      CMD_HW_STATUS:          csr.sel = REG_HW_STATUS;
      CMD_INDIRECT_FIFO_DATA: csr.sel = REG_FIFO_DATA;
      default:                csr.sel = REG_NONE;
    endcase
  end

  // Response length per register
  always_comb begin
    unique case (csr.sel)
      REG_PROT_CAP:        rd_len = PROT_CAP_LEN;
      REG_DEVICE_STATUS:   rd_len = DEVICE_STATUS_LEN;
      REG_DEVICE_RESET:    rd_len = DEVICE_RESET_LEN;
      REG_RECOVERY_CTRL:   rd_len = RECOVERY_CTRL_LEN;
      REG_RECOVERY_STATUS: rd_len = RECOVERY_STATUS_LEN;
      REG_HW_STATUS:       rd_len = HW_STATUS_LEN;
      default:             rd_len = UNKNOWN_LEN;
    endcase
  end

  assign writable = (csr.sel == REG_DEVICE_RESET) || (csr.sel == REG_RECOVERY_CTRL);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (cmd.cmd_valid) begin
          if (cmd.error != PROTOCOL_OK) state_d = Error;
          else if (cmd.is_rd) state_d = CsrRead;
          else if (cmd.len == '0) state_d = Done;
          else state_d = CsrWrite;
        end
      end
      CsrWrite:    if (rx_ack_i && (dcnt == 16'd1)) state_d = Done;
      CsrRead:     state_d = CsrReadLen;
      CsrReadLen:  if (res_ready_i) state_d = CsrReadData;
      CsrReadData: if (byte_xfer && (dcnt == 16'd1)) state_d = Done;
      Error:       state_d = Done;
      Done:        state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      dcnt     <= '0;
      bcnt     <= '0;
      first_q  <= 1'b0;
      rx_req_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      rx_req_o <= 1'b0;
      unique case (state_q)
        Idle: begin
          if (cmd.cmd_valid) begin
            // Word count rounded up
            dcnt     <= cmd.len[15:2] + {15'd0, |cmd.len[1:0]};
            first_q  <= 1'b1;
            rx_req_o <= (cmd.error == PROTOCOL_OK) && !cmd.is_rd && (cmd.len != '0);
          end
        end
        CsrWrite: begin
          if (rx_ack_i) begin
            dcnt     <= dcnt - 16'd1;
            first_q  <= 1'b0;
            rx_req_o <= (dcnt != 16'd1);
          end
        end
        CsrRead: begin
          dcnt <= rd_len;
          bcnt <= '0;
        end
        CsrReadData: begin
          if (byte_xfer) begin
            dcnt <= dcnt - 16'd1;
            bcnt <= bcnt + 2'd1;
          end
        end
        default: ;
      endcase
    end
  end

  // Register snapshot for the response
  always_ff @(posedge clk_i) begin
    if (state_q == CsrRead) begin
      csr_data <= csr.rdata;
    end
  end

  // Only the first word reaches a writable register
  assign csr.we          = (state_q == CsrWrite) && rx_ack_i && first_q && writable;
  assign csr.wdata       = rx_word_i;
  assign csr.status_we   = (state_q == Done);
  assign csr.status_code = cmd.error;
  assign csr.payload_set = (state_q == Done) && !cmd.is_rd &&
                           (cmd.cmd == CMD_INDIRECT_FIFO_DATA) && (cmd.error == PROTOCOL_OK);
  assign cmd.done        = (state_q == Done);
  assign rx_clr_o        = (state_q == Error);

  assign res_valid_o  = (state_q == CsrReadLen);
  assign res_len_o    = rd_len;
  assign res_dvalid_o = (state_q == CsrReadData);
  assign res_data_o   = csr_data[8*bcnt +: 8];
  assign res_dlast_o  = res_dvalid_o && (dcnt == 16'd1);

endmodule

//--- design/recovery_rx_queue.sv
// Four-word queue between receiver and executor, read by request with a one-cycle acknowledge
module recovery_rx_queue
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] push_word_i,
  input  logic        rx_req_i,
  input  logic        rx_clr_i,
  output logic        rx_ack_o,
  output logic [31:0] rx_word_o
);

  logic [31:0]         mem [RX_QUEUE_DEPTH];
  logic [RX_PTR_W-1:0] wr_ptr;
  logic [RX_PTR_W-1:0] rd_ptr;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_word_i;
    end
    if (rx_req_i) begin
      rx_word_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rx_ack_o <= 1'b0;
    end else begin
      rx_ack_o <= rx_req_i;
      if (rx_clr_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (push_i) wr_ptr <= wr_ptr + 1'b1;
        if (rx_req_i) rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

//--- design/recovery_receiver.sv
// Parses host packets, checks the XOR checksum and packs write data into queue words
module recovery_receiver
  import recovery_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  byte_valid_i,
  input  logic [7:0]            byte_i,
  input  logic                  byte_last_i,
  input  logic                  pkt_rd_i,
  recovery_cmd_if.source        cmd,
  output logic                  push_o,
  output logic [31:0]           push_word_o,
  output logic                  busy_o
);

  logic              accept;
  logic [1:0]        hdr_cnt;
  logic [15:0]       data_left;
  logic [1:0]        wbyte_cnt;
  logic [RX_PTR_W:0] word_cnt;
  logic [7:0]        pec_q;
  logic [31:0]       word_q;
  logic [31:0]       word_d;
  logic              is_data;
  logic              word_done;

  // Bytes are ignored while a command waits for the executor
  assign accept    = byte_valid_i && !cmd.cmd_valid;
  assign is_data   = (hdr_cnt == 2'd3) && (data_left != '0);
  assign word_done = is_data && ((wbyte_cnt == 2'd3) || (data_left == 16'd1));
  assign busy_o    = cmd.cmd_valid;

  always_comb begin
    word_d = word_q;
    word_d[8*wbyte_cnt +: 8] = byte_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_cnt       <= '0;
      data_left     <= '0;
      wbyte_cnt     <= '0;
      word_cnt      <= '0;
      pec_q         <= '0;
      push_o        <= 1'b0;
      cmd.cmd_valid <= 1'b0;
      cmd.is_rd     <= 1'b0;
      cmd.cmd       <= CMD_PROT_CAP;
      cmd.len       <= '0;
      cmd.error     <= PROTOCOL_OK;
    end else begin
      push_o <= 1'b0;
      if (cmd.done) begin
        cmd.cmd_valid <= 1'b0;
      end
      if (accept) begin
        pec_q <= (hdr_cnt == 2'd0) ? byte_i : (pec_q ^ byte_i);
        if (byte_last_i) begin
          hdr_cnt       <= '0;
          cmd.cmd_valid <= 1'b1;
          cmd.is_rd     <= pkt_rd_i;
          if (!pkt_rd_i && (byte_i != pec_q)) begin
            cmd.error <= PROTOCOL_ERROR_CRC;
          end else if (!pkt_rd_i && (cmd.len > MAX_WRITE_LEN)) begin
            cmd.error <= PROTOCOL_ERROR_LENGTH;
          end else begin
            cmd.error <= PROTOCOL_OK;
          end
        end else if (hdr_cnt != 2'd3) begin
          hdr_cnt <= hdr_cnt + 2'd1;
        end
        unique case (hdr_cnt)
          2'd0: begin
            cmd.cmd   <= recovery_cmd_e'(byte_i);
            cmd.len   <= '0;
            wbyte_cnt <= '0;
            word_cnt  <= '0;
          end
          2'd1: cmd.len[7:0] <= byte_i;
          2'd2: begin
            cmd.len[15:8] <= byte_i;
            data_left     <= {byte_i, cmd.len[7:0]};
          end
          default: begin
            if (is_data) begin
              data_left <= data_left - 16'd1;
              wbyte_cnt <= word_done ? 2'd0 : wbyte_cnt + 2'd1;
              // Words beyond the queue depth are dropped
              if (word_done && (word_cnt < RX_QUEUE_DEPTH[RX_PTR_W:0])) begin
                word_cnt <= word_cnt + 1'b1;
                push_o   <= 1'b1;
              end
            end
          end
        endcase
      end
    end
  end

  // Word assembly, unused byte lanes of a short last word stay zero
  always_ff @(posedge clk_i) begin
    if (accept && (hdr_cnt == 2'd0)) begin
      word_q <= '0;
    end else if (accept && is_data) begin
      word_q      <= word_done ? '0 : word_d;
      push_word_o <= word_d;
    end
  end

endmodule

//--- design/recovery_csr_if.sv
// Register access path from the command executor to the recovery register bank
interface recovery_csr_if
  import recovery_pkg::*;
();

  recovery_reg_e    sel;
  logic [31:0]      wdata;
  logic             we;
  logic             status_we;
  protocol_status_e status_code;
  logic             payload_set;
  logic [31:0]      rdata;

  modport master(output sel, wdata, we, status_we, status_code, payload_set, input rdata);

  modport slave(input sel, wdata, we, status_we, status_code, payload_set, output rdata);

endinterface

//--- design/recovery_cmd_if.sv
// Decoded command handshake between the packet receiver and the command executor
interface recovery_cmd_if
  import recovery_pkg::*;
();

  logic             cmd_valid;
  logic             is_rd;
  recovery_cmd_e    cmd;
  logic [15:0]      len;
  protocol_status_e error;
  logic             done;

  modport source(output cmd_valid, is_rd, cmd, len, error, input done);

  modport sink(input cmd_valid, is_rd, cmd, len, error, output done);

endinterface

//--- design/recovery_pkg.sv
// Shared command codes, register map sizes and state types, imported by all RTL and test files
package recovery_pkg;

  // Recovery command codes
  typedef enum logic [7:0] {
    CMD_PROT_CAP           = 8'd34,
    CMD_DEVICE_STATUS      = 8'd36,
    CMD_DEVICE_RESET       = 8'd37,
    CMD_RECOVERY_CTRL      = 8'd38,
    CMD_RECOVERY_STATUS    = 8'd39,
    CMD_HW_STATUS          = 8'd40,
    CMD_INDIRECT_FIFO_DATA = 8'd47
  } recovery_cmd_e;

  // Protocol status, byte 1 of DEVICE_STATUS
  typedef enum logic [7:0] {
    PROTOCOL_OK           = 8'h00,
    PROTOCOL_ERROR_LENGTH = 8'h03,
    PROTOCOL_ERROR_CRC    = 8'h04
  } protocol_status_e;

  // Read lengths in bytes
  localparam logic [15:0] PROT_CAP_LEN        = 16'd4;
  localparam logic [15:0] DEVICE_STATUS_LEN   = 16'd4;
  localparam logic [15:0] DEVICE_RESET_LEN    = 16'd3;
  localparam logic [15:0] RECOVERY_CTRL_LEN   = 16'd3;
  localparam logic [15:0] RECOVERY_STATUS_LEN = 16'd2;
  localparam logic [15:0] HW_STATUS_LEN       = 16'd4;
  localparam logic [15:0] UNKNOWN_LEN         = 16'd4;

  // Constant register contents
  localparam logic [31:0] PROT_CAP_VALUE        = 32'h3150_4352;
  localparam logic [31:0] RECOVERY_STATUS_VALUE = 32'h0000_0011;

  localparam int unsigned RX_QUEUE_DEPTH = 4;
  localparam int unsigned RX_PTR_W       = $clog2(RX_QUEUE_DEPTH);
  localparam logic [15:0] MAX_WRITE_LEN  = 16'd16;
  localparam logic [7:0]  IMAGE_ACTIVATE_CODE = 8'h0F;

  typedef enum logic [2:0] {
    REG_PROT_CAP, REG_DEVICE_STATUS, REG_DEVICE_RESET, REG_RECOVERY_CTRL,
    REG_RECOVERY_STATUS, REG_HW_STATUS, REG_FIFO_DATA, REG_NONE
  } recovery_reg_e;

  typedef enum logic [2:0] {
    Idle, CsrWrite, CsrRead, CsrReadLen, CsrReadData, Error, Done
  } exec_state_e;

endpackage
